/* verilog.f */
+incdir+rtl
rtl/mem_pkg.sv
rtl/axi_lite_if.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/data_ram.sv
rtl/mem_ctrl.sv
rtl/mem_stage.sv
tb/tb_clock.sv
tb/mem_stage_assertions.sv
tb/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
# Builds the memory stage testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert --top-module mem_stage_tb -f verilog.f \
    -o mem_stage_sim > build.log 2>&1 \
    && ./obj_dir/mem_stage_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

/* tb/mem_stage_tb.sv */
/*
 * Memory stage testbench.
 * Directed tests against a byte-wide model of the data RAM,
 * stream handshake tasks, compare tasks and the summary.
 */

`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_stage_tb import mem_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 50;
    localparam int MODEL_BYTES    = 4 * `MEM_RAM_WORDS;

    logic     cache;
    logic     rstart;
    logic     up_valid;
    logic     up_ready;
    op_t      up_op;
    addr_t    up_alu;
    word_t    up_rs2;
    reg_idx_t up_rd;
    logic     down_valid;
    logic     down_ready;
    op_t      down_op;
    reg_idx_t down_rd;
    word_t    down_data;

    logic [7:0]  model [MODEL_BYTES];    // Byte image of the RAM.
    logic [31:0] lcg_state = 32'h6cedcb81;
    int          checks    = 0;
    int          errors    = 0;
    int          tests     = 0;
    int          test_start_errors;
    logic        timed_out = 1'b0;
    op_t         got_op;                 // Last beat taken downstream.
    reg_idx_t    got_rd;
    word_t       got_data;

    tb_clock clock_gen (.cache(cache), .rstart(rstart));

    mem_stage mem_stage_inst (
        .cache      (cache),
        .rstart     (rstart),
        .up_valid   (up_valid),
        .up_ready   (up_ready),
        .up_op      (up_op),
        .up_alu     (up_alu),
        .up_rs2     (up_rs2),
        .up_rd      (up_rd),
        .down_valid (down_valid),
        .down_ready (down_ready),
        .down_op    (down_op),
        .down_rd    (down_rd),
        .down_data  (down_data)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ----------------------------------------------------------------------
    // Memory model
    // ----------------------------------------------------------------------

    function automatic int byte_index(addr_t a);
        return int'(a[`MEM_RAM_ADDR_BITS+1:0]);     // Upper bits alias.
    endfunction

    task automatic model_store(op_t op, addr_t a, word_t data);
        int base;
        base = byte_index(a);
        case (op)
            OP_STORE_WORD: begin
                for (int i = 0; i < 4; i++) begin
                    model[(base & ~3) + i] = data[8*i +: 8];
                end
            end
            OP_STORE_HALF: begin
                model[base & ~1]       = data[7:0];
                model[(base & ~1) + 1] = data[15:8];
            end
            OP_STORE_BYTE: begin
                model[base] = data[7:0];
            end
            default: begin
            end
        endcase
    endtask

    function automatic word_t model_load(op_t op, addr_t a);
        int          base;
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        base = byte_index(a);
        w = {model[(base & ~3) + 3], model[(base & ~3) + 2],
             model[(base & ~3) + 1], model[base & ~3]};
        b = model[base];
        h = {model[(base & ~1) + 1], model[base & ~1]};
        case (op)
            OP_LOAD_HALF:   return {{16{h[15]}}, h};
            OP_LOAD_BYTE:   return {{24{b[7]}}, b};
            OP_LOAD_HALF_U: return {16'h0000, h};
            OP_LOAD_BYTE_U: return {24'h000000, b};
            default:        return w;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_word(string name, word_t exp, word_t act);
        if (timed_out) return;
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_op(string name, op_t exp, op_t act);
        if (timed_out) return;
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected op %0d, actual op %0d", name, exp, act);
        end
    endtask

    task automatic check_rd(string name, reg_idx_t exp, reg_idx_t act);
        if (timed_out) return;
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected rd %0d, actual rd %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (timed_out) return;
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // Stream handshakes
    // ----------------------------------------------------------------------

    // Offers one beat and returns just after the edge that took it.
    task automatic send_beat(op_t op, addr_t alu, word_t rs2, reg_idx_t rd);
        int wait_cycles;
        if (timed_out) return;
        up_valid    = 1'b1;
        up_op       = op;
        up_alu      = alu;
        up_rs2      = rs2;
        up_rd       = rd;
        wait_cycles = 0;
        while (!up_ready) begin
            @(posedge cache);
            #1;
            wait_cycles++;
            if (wait_cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: up_ready stayed low, the beat was never accepted");
                errors++;
                timed_out = 1'b1;
                up_valid  = 1'b0;
                return;
            end
        end
        @(posedge cache);
        #1;
        up_valid = 1'b0;
    endtask

    task automatic collect_beat();
        int wait_cycles;
        if (timed_out) return;
        down_ready  = 1'b1;
        wait_cycles = 0;
        while (!down_valid) begin
            @(posedge cache);
            #1;
            wait_cycles++;
            if (wait_cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: down_valid never rose, no writeback beat came out");
                errors++;
                timed_out = 1'b1;
                return;
            end
        end
        got_op   = down_op;
        got_rd   = down_rd;
        got_data = down_data;
        @(posedge cache);                                // Beat leaves here.
        #1;
    endtask

    task automatic run_op(op_t op, addr_t alu, word_t rs2, reg_idx_t rd);
        send_beat(op, alu, rs2, rd);
        collect_beat();
    endtask

    // Stores write back the ALU value, which is the address.
    task automatic store_and_check(string name, op_t op, addr_t a, word_t data);
        reg_idx_t rd;
        rd = reg_idx_t'(lcg_next());
        run_op(op, a, data, rd);
        model_store(op, a, data);
        check_op(name, op, got_op);
        check_rd(name, rd, got_rd);
        check_word(name, a, got_data);
    endtask

    task automatic load_and_check(string name, op_t op, addr_t a);
        reg_idx_t rd;
        rd = reg_idx_t'(lcg_next());
        run_op(op, a, lcg_next(), rd);
        check_op(name, op, got_op);
        check_rd(name, rd, got_rd);
        check_word(name, model_load(op, a), got_data);
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(string name);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - test_start_errors);
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------

    task automatic reset_state();
        begin_test();
        check_bit("reset down_valid", 1'b0, down_valid);
        check_bit("reset up_ready", 1'b1, up_ready);
        end_test("reset state");
    endtask

    task automatic alu_pass();
        op_t      op;
        addr_t    alu;
        reg_idx_t rd;
        begin_test();
        for (int i = 0; i < 4; i++) begin
            op  = (i == 3) ? OP_NULL : OP_ALU;
            alu = lcg_next();
            rd  = reg_idx_t'(lcg_next());
            run_op(op, alu, lcg_next(), rd);
            check_op("alu pass op", op, got_op);
            check_rd("alu pass rd", rd, got_rd);
            check_word("alu pass data", alu, got_data);
        end
        end_test("alu pass-through");
    endtask

    task automatic word_round_trip();
        addr_t a;
        begin_test();
        for (int i = 0; i < 6; i++) begin
            a = lcg_next() & 32'h0000_0ffc;
            store_and_check("word store", OP_STORE_WORD, a, lcg_next());
            load_and_check("word load", OP_LOAD_WORD, a);
        end
        end_test("word store and load");
    endtask

    task automatic sub_word_stores();
        addr_t base;
        begin_test();
        base = 32'h0000_0140;
        store_and_check("sub-word init", OP_STORE_WORD, base, lcg_next());
        for (int lane = 0; lane < 4; lane++) begin
            store_and_check("byte store", OP_STORE_BYTE, base + addr_t'(lane), lcg_next());
            load_and_check("byte lane word load", OP_LOAD_WORD, base);
        end
        for (int half = 0; half < 2; half++) begin
            store_and_check("half store", OP_STORE_HALF, base + addr_t'(2 * half), lcg_next());
            load_and_check("half lane word load", OP_LOAD_WORD, base);
        end
        end_test("sub-word stores");
    endtask

    task automatic sign_extension();
        addr_t base;
        begin_test();
        base = 32'h0000_0280;
        store_and_check("sign init", OP_STORE_WORD, base, lcg_next() | 32'h8080_8080);
        for (int lane = 0; lane < 4; lane++) begin
            load_and_check("signed byte", OP_LOAD_BYTE, base + addr_t'(lane));
            load_and_check("unsigned byte", OP_LOAD_BYTE_U, base + addr_t'(lane));
        end
        for (int half = 0; half < 2; half++) begin
            load_and_check("signed half", OP_LOAD_HALF, base + addr_t'(2 * half));
            load_and_check("unsigned half", OP_LOAD_HALF_U, base + addr_t'(2 * half));
        end
        end_test("sign handling");
    endtask

    task automatic back_pressure();
        word_t    first_alu;
        word_t    second_alu;
        reg_idx_t first_rd;
        reg_idx_t second_rd;
        begin_test();
        first_alu  = lcg_next();
        second_alu = lcg_next();
        first_rd   = 5'd3;
        second_rd  = 5'd17;
        down_ready = 1'b0;
        send_beat(OP_ALU, first_alu, '0, first_rd);
        up_valid = 1'b1;                                 // Next beat waits upstream.
        up_op    = OP_NULL;
        up_alu   = second_alu;
        up_rs2   = '0;
        up_rd    = second_rd;
        repeat (5) begin
            check_bit("stall down_valid", 1'b1, down_valid);
            check_bit("stall up_ready", 1'b0, up_ready);
            check_op("stall op", OP_ALU, down_op);
            check_word("stall data", first_alu, down_data);
            check_rd("stall rd", first_rd, down_rd);
            @(posedge cache);
            #1;
        end
        down_ready = 1'b1;
        @(posedge cache);
        #1;
        check_bit("released down_valid", 1'b0, down_valid);   // Not offered twice.
        send_beat(OP_NULL, second_alu, '0, second_rd);
        collect_beat();
        check_op("second beat op", OP_NULL, got_op);
        check_rd("second beat rd", second_rd, got_rd);
        check_word("second beat data", second_alu, got_data);
        end_test("back-pressure");
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        int wait_cycles;
        up_valid    = 1'b0;
        up_op       = OP_NULL;
        up_alu      = '0;
        up_rs2      = '0;
        up_rd       = '0;
        down_ready  = 1'b1;
        wait_cycles = 0;
        do begin
            @(negedge cache);                            // Reset sampled mid-cycle.
            wait_cycles++;
            if (wait_cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: reset was never released");
                errors++;
                timed_out = 1'b1;
            end
        end while (rstart && !timed_out);
        @(posedge cache);
        #1;

        reset_state();
        alu_pass();
        word_round_trip();
        sub_word_stores();
        sign_extension();
        back_pressure();

        $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tb/mem_stage_assertions.sv */
/*
 * Handshake assertions for the stage controller.
 * AXI-lite valids, writeback valid and upstream ready.
 */

`timescale 1ns/1ps

module mem_stage_assertions (
    input logic cache,
    input logic rstart,
    input logic up_ready,
    input logic down_valid,
    input logic down_ready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bready,
    input logic arvalid,
    input logic arready,
    input logic rready
);

    // ----------------------------------------------------------------------
    // AXI-lite request channels
    // ----------------------------------------------------------------------

    aw_hold: assert property (@(posedge cache) disable iff (rstart)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge cache) disable iff (rstart)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    ar_hold: assert property (@(posedge cache) disable iff (rstart)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // ----------------------------------------------------------------------
    // Stream side
    // ----------------------------------------------------------------------

    down_hold: assert property (@(posedge cache) disable iff (rstart)
        down_valid && !down_ready |=> down_valid)
        else $error("down_valid dropped before down_ready");

    // A held writeback beat or an open bus transaction blocks the next operation.
    busy_block: assert property (@(posedge cache) disable iff (rstart)
        (down_valid || awvalid || wvalid || bready || arvalid || rready) |-> !up_ready)
        else $error("up_ready high while a beat or a bus transaction is pending");

endmodule

bind mem_ctrl mem_stage_assertions mem_stage_assertions_inst (
    .cache      (cache),
    .rstart     (rstart),
    .up_ready   (up_ready),
    .down_valid (down_valid),
    .down_ready (down_ready),
    .awvalid    (bus.awvalid),
    .awready    (bus.awready),
    .wvalid     (bus.wvalid),
    .wready     (bus.wready),
    .bready     (bus.bready),
    .arvalid    (bus.arvalid),
    .arready    (bus.arready),
    .rready     (bus.rready)
);

/* tb/tb_clock.sv */
/*
 * Testbench clock and reset source.
 * 40 ns clock, reset held for the first two rising edges.
 */

`timescale 1ns/1ps

module tb_clock (
    output logic cache,
    output logic rstart
);

    initial begin
        cache  = 1'b0;
        rstart = 1'b1;
        repeat (2) @(posedge cache);
        #1;
        rstart = 1'b0;                  // Released just after the second edge.
    end

    always #20 cache = ~cache;

endmodule

/* rtl/mem_stage.sv */
/*
 * Memory stage top level.
 * Controller, store and load aligners and the data RAM on plain ports.
 */

`timescale 1ns/1ps

module mem_stage import mem_pkg::*; (
    input  logic     cache,
    input  logic     rstart,
    input  logic     up_valid,
    output logic     up_ready,
    input  op_t      up_op,
    input  addr_t    up_alu,
    input  word_t    up_rs2,
    input  reg_idx_t up_rd,
    output logic     down_valid,
    input  logic     down_ready,
    output op_t      down_op,
    output reg_idx_t down_rd,
    output word_t    down_data
);

    op_t        st_op;
    logic [1:0] st_addr_lo;
    word_t      st_din;
    word_t      st_data;
    strb_t      st_strb;
    word_t      ld_word;

    axi_lite_if bus ();

    mem_ctrl mem_ctrl_inst (
        .cache      (cache),
        .rstart     (rstart),
        .up_valid   (up_valid),
        .up_ready   (up_ready),
        .up_op      (up_op),
        .up_alu     (up_alu),
        .up_rs2     (up_rs2),
        .up_rd      (up_rd),
        .down_valid (down_valid),
        .down_ready (down_ready),
        .down_op    (down_op),
        .down_rd    (down_rd),
        .down_data  (down_data),
        .st_op      (st_op),
        .st_addr_lo (st_addr_lo),
        .st_din     (st_din),
        .st_data    (st_data),
        .st_strb    (st_strb),
        .ld_word    (ld_word),
        .bus        (bus.master)
    );

    store_align store_align_inst (
        .op      (st_op),
        .addr_lo (st_addr_lo),
        .din     (st_din),
        .dout    (st_data),
        .strb    (st_strb)
    );

    // Same held op and offset as the store side, fed with the read word.
    load_align load_align_inst (
        .op      (st_op),
        .addr_lo (st_addr_lo),
        .din     (bus.rdata),
        .dout    (ld_word)
    );

    data_ram data_ram_inst (
        .cache  (cache),
        .rstart (rstart),
        .bus    (bus.slave)
    );

endmodule

/* rtl/mem_ctrl.sv */
/*
 * Memory stage controller.
 * Stream handshakes, beat capture, AXI-lite write and read FSMs,
 * and the writeback register.
 */

`timescale 1ns/1ps

module mem_ctrl import mem_pkg::*; (
    input  logic       cache,
    input  logic       rstart,
    input  logic       up_valid,
    output logic       up_ready,
    input  op_t        up_op,
    input  addr_t      up_alu,
    input  word_t      up_rs2,
    input  reg_idx_t   up_rd,
    output logic       down_valid,
    input  logic       down_ready,
    output op_t        down_op,
    output reg_idx_t   down_rd,
    output word_t      down_data,
    output op_t        st_op,
    output logic [1:0] st_addr_lo,
    output word_t      st_din,
    input  word_t      st_data,
    input  strb_t      st_strb,
    input  word_t      ld_word,
    axi_lite_if.master bus
);

    op_t         op_q;
    addr_t       alu_q;
    word_t       rs2_q;
    reg_idx_t    rd_q;
    ctrl_state_t wr_state;
    ctrl_state_t rd_state;
    logic        accept;
    logic        aw_done;
    logic        w_done;
    logic        wr_done;
    logic        rd_done;

    // Only one operation is held at a time.
    assign up_ready = (wr_state == IDLE) && (rd_state == IDLE) && !down_valid;
    assign accept   = up_valid && up_ready;

    assign aw_done = !bus.awvalid || bus.awready;
    assign w_done  = !bus.wvalid || bus.wready;
    assign wr_done = (wr_state == RESP) && bus.bvalid;   // B transfer.
    assign rd_done = (rd_state == DATA) && bus.rvalid;   // R transfer.

    always_ff @(posedge cache) begin
        if (accept) begin
            op_q  <= up_op;
            alu_q <= up_alu;
            rs2_q <= up_rs2;
            rd_q  <= up_rd;
        end
    end

    assign st_op      = op_q;
    assign st_addr_lo = alu_q[1:0];
    assign st_din     = rs2_q;

    // Payload comes from the held beat, so it stays stable under valid.
    assign bus.awaddr = {alu_q[31:2], 2'b00};
    assign bus.araddr = {alu_q[31:2], 2'b00};
    assign bus.wdata  = st_data;
    assign bus.wstrb  = st_strb;

    // ----------------------------------------------------------------------
    // Write FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge cache) begin
        if (rstart) begin
            wr_state    <= IDLE;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
            bus.bready  <= 1'b0;
        end else begin
            case (wr_state)
                IDLE: begin
                    if (accept && is_store(up_op)) begin
                        bus.awvalid <= 1'b1;
                        bus.wvalid  <= 1'b1;
                        wr_state    <= ADDR;
                    end
                end
                ADDR: begin
                    if (bus.awready) bus.awvalid <= 1'b0;
                    if (bus.wready) bus.wvalid <= 1'b0;
                    if (aw_done && w_done) begin
                        bus.bready <= 1'b1;
                        wr_state   <= RESP;
                    end else if (aw_done) begin
                        wr_state <= DATA;               // Address taken, data pending.
                    end
                end
                DATA: begin
                    if (bus.wready) begin
                        bus.wvalid <= 1'b0;
                        bus.bready <= 1'b1;
                        wr_state   <= RESP;
                    end
                end
                RESP: begin
                    if (bus.bvalid) begin
                        bus.bready <= 1'b0;
                        wr_state   <= IDLE;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Read FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge cache) begin
        if (rstart) begin
            rd_state    <= IDLE;
            bus.arvalid <= 1'b0;
            bus.rready  <= 1'b0;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (accept && is_load(up_op)) begin
                        bus.arvalid <= 1'b1;
                        rd_state    <= ADDR;
                    end
                end
                ADDR: begin
                    if (bus.arready) begin
                        bus.arvalid <= 1'b0;
                        bus.rready  <= 1'b1;
                        rd_state    <= DATA;
                    end
                end
                DATA: begin
                    if (bus.rvalid) begin
                        bus.rready <= 1'b0;
                        rd_state   <= IDLE;
                    end
                end
                default: begin
                    rd_state <= IDLE;                   // No response phase on reads.
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Writeback
    // ----------------------------------------------------------------------

    always_ff @(posedge cache) begin
        if (rstart) begin
            down_valid <= 1'b0;
        end else if (accept && !is_load(up_op) && !is_store(up_op)) begin
            down_valid <= 1'b1;
        end else if (wr_done || rd_done) begin
            down_valid <= 1'b1;
        end else if (down_valid && down_ready) begin
            down_valid <= 1'b0;
        end
    end

    // ALU value by default; loads replace it when the read returns.
    always_ff @(posedge cache) begin
        if (accept) begin
            down_op   <= up_op;
            down_rd   <= up_rd;
            down_data <= up_alu;
        end else if (rd_done) begin
            down_data <= ld_word;
        end
    end

endmodule

/* rtl/data_ram.sv */
/*
 * Data memory with an AXI-lite slave port.
 * Byte-strobed writes, single-beat reads, always an OKAY answer.
 */

`timescale 1ns/1ps

`include "mem_defs.svh"

module data_ram import mem_pkg::*; (
    input  logic      cache,
    input  logic      rstart,
    axi_lite_if.slave bus
);

    word_t mem [`MEM_RAM_WORDS];

    logic [`MEM_RAM_ADDR_BITS-1:0] wr_idx;
    logic [`MEM_RAM_ADDR_BITS-1:0] rd_idx;
    logic                          wr_fire;
    logic                          rd_fire;

    // Word index sits above the byte offset; upper address bits drop out.
    assign wr_idx = bus.awaddr[`MEM_RAM_ADDR_BITS+1:2];
    assign rd_idx = bus.araddr[`MEM_RAM_ADDR_BITS+1:2];

    // ----------------------------------------------------------------------
    // Write channel
    // ----------------------------------------------------------------------

    // Address and data are taken together, once no response is pending.
    assign bus.awready = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign bus.wready  = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign wr_fire     = bus.awvalid && bus.awready;

    always_ff @(posedge cache) begin
        if (wr_fire) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (bus.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];   // Strobed lanes only.
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read channel
    // ----------------------------------------------------------------------

    assign bus.arready = bus.arvalid && !bus.rvalid;   // One read in flight.
    assign rd_fire     = bus.arvalid && bus.arready;

    always_ff @(posedge cache) begin
        if (rd_fire) begin
            bus.rdata <= mem[rd_idx];
        end
    end

    // Response valids, held until the master takes them.
    always_ff @(posedge cache) begin
        if (rstart) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bvalid && bus.bready) begin
                bus.bvalid <= 1'b0;
            end
            if (rd_fire) begin
                bus.rvalid <= 1'b1;
            end else if (bus.rvalid && bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

endmodule

/* rtl/load_align.sv */
/*
 * Load alignment.
 * Picks the addressed byte or half of a read word and extends it.
 */

`timescale 1ns/1ps

module load_align import mem_pkg::*; (
    input  op_t        op,
    input  logic [1:0] addr_lo,
    input  word_t      din,
    output word_t      dout
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = din[{addr_lo, 3'b000} +: 8];          // Lane by byte offset.
    assign half_sel = addr_lo[1] ? din[31:16] : din[15:0];  // Upper or lower half.

    always_comb begin
        case (op)
            OP_LOAD_HALF: begin
                dout = {{16{half_sel[15]}}, half_sel};
            end
            OP_LOAD_BYTE: begin
                dout = {{24{byte_sel[7]}}, byte_sel};
            end
            OP_LOAD_HALF_U: begin
                dout = {16'h0000, half_sel};
            end
            OP_LOAD_BYTE_U: begin
                dout = {24'h000000, byte_sel};
            end
            default: begin
                dout = din;                                 // Word loads as read.
            end
        endcase
    end

endmodule

/* rtl/store_align.sv */
/*
 * Store alignment.
 * Moves the store value into its byte lane and builds the write strobes.
 */

`timescale 1ns/1ps

module store_align import mem_pkg::*; (
    input  op_t        op,
    input  logic [1:0] addr_lo,
    input  word_t      din,
    output word_t      dout,
    output strb_t      strb
);

    always_comb begin
        dout = din;
        strb = '0;
        case (op)
            OP_STORE_WORD: begin
                strb = '1;                            // Whole word.
            end
            OP_STORE_HALF: begin
                if (addr_lo[1]) begin
                    dout = din << 16;                 // Upper half lane.
                    strb = 4'b1100;
                end else begin
                    strb = 4'b0011;
                end
            end
            OP_STORE_BYTE: begin
                dout = din << {addr_lo, 3'b000};      // Byte lane by offset.
                strb = strb_t'(1) << addr_lo;
            end
            default: begin
                strb = '0;                            // No write for other ops.
            end
        endcase
    end

endmodule

/* rtl/axi_lite_if.sv */
/*
 * AXI-lite link between the stage controller and the data RAM.
 * Master and slave modports; no prot bits and no response code.
 */

`timescale 1ns/1ps

interface axi_lite_if import mem_pkg::*; ();

    logic  awvalid;
    logic  awready;
    addr_t awaddr;

    logic  wvalid;
    logic  wready;
    word_t wdata;
    strb_t wstrb;

    logic  bvalid;
    logic  bready;

    logic  arvalid;
    logic  arready;
    addr_t araddr;

    logic  rvalid;
    logic  rready;
    word_t rdata;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, arready, rvalid, rdata
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, arready, rvalid, rdata
    );

endinterface

/* rtl/mem_pkg.sv */
/*
 * Shared types of the memory stage.
 * Vector typedefs, op codes, bus FSM states and op class helpers.
 */

`include "mem_defs.svh"

package mem_pkg;

    typedef logic [`MEM_WORD_BITS-1:0]   word_t;     // Data word.
    typedef logic [31:0]                 addr_t;     // Byte address.
    typedef logic [`MEM_WORD_BITS/8-1:0] strb_t;     // One bit per byte lane.
    typedef logic [4:0]                  reg_idx_t;  // Register file index.

    typedef enum logic [3:0] {
        OP_NULL        = 4'd0,
        OP_ALU         = 4'd1,
        OP_LOAD_WORD   = 4'd2,
        OP_LOAD_HALF   = 4'd3,
        OP_LOAD_BYTE   = 4'd4,
        OP_LOAD_HALF_U = 4'd5,
        OP_LOAD_BYTE_U = 4'd6,
        OP_STORE_WORD  = 4'd7,
        OP_STORE_HALF  = 4'd8,
        OP_STORE_BYTE  = 4'd9
    } op_t;

    typedef enum logic [1:0] { IDLE, ADDR, DATA, RESP } ctrl_state_t;

    function automatic logic is_load(op_t op);
        return op inside {OP_LOAD_WORD, OP_LOAD_HALF, OP_LOAD_BYTE,
                          OP_LOAD_HALF_U, OP_LOAD_BYTE_U};
    endfunction

    function automatic logic is_store(op_t op);
        return op inside {OP_STORE_WORD, OP_STORE_HALF, OP_STORE_BYTE};
    endfunction

endpackage

/* rtl/mem_defs.svh */
/*
 * Sizing macros for the memory stage.
 * Data word width, data RAM depth and RAM word index width.
 */

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Width of one data word in bits.
`define MEM_WORD_BITS 32

// Data RAM depth in words.
`define MEM_RAM_WORDS 1024

// Word index width, log2 of the depth.
`define MEM_RAM_ADDR_BITS 10

`endif
